// File: hdl/display_pkg.sv
package display_pkg;

    // 1024x768 at 60 Hz, 65 MHz pixel clock
    localparam logic [10:0] H_DISP  = 11'd1024;
    localparam logic [10:0] H_FRONT = 11'd24;
    localparam logic [10:0] H_SYNC  = 11'd136;
    localparam logic [10:0] H_BACK  = 11'd160;
    localparam logic [10:0] H_TOTAL = 11'd1344;  // disp + front + sync + back

    localparam logic [10:0] V_DISP  = 11'd768;
    localparam logic [10:0] V_FRONT = 11'd3;
    localparam logic [10:0] V_SYNC  = 11'd6;
    localparam logic [10:0] V_BACK  = 11'd29;
    localparam logic [10:0] V_TOTAL = 11'd806;

    // progress bar
    localparam logic [10:0] PROG_LEFT = 11'd20;
    localparam logic [10:0] PROG_TOP  = 11'd120;
    localparam logic [10:0] PROG_W    = 11'd900;
    localparam logic [10:0] PROG_H    = 11'd40;
    localparam logic [10:0] PROG_STEP = PROG_W / 11'd100;  // pixels per percent

    // song title banner
    localparam logic [10:0] TITLE_LEFT = 11'd100;
    localparam logic [10:0] TITLE_TOP  = 11'd20;
    localparam logic [10:0] TITLE_W    = 11'd64;
    localparam logic [10:0] TITLE_H    = 11'd16;

    // keyboard
    localparam logic [10:0] KEY_LEFT    = 11'd20;
    localparam logic [10:0] KEY_TOP     = 11'd200;
    localparam logic [4:0]  KEY_PITCH   = 5'd19;
    localparam logic [4:0]  KEY_GAP     = 5'd5;
    localparam logic [10:0] HALF_OFFSET = 11'd9;   // sharps sit half a pitch over
    localparam logic [10:0] MAIN_KEY_H  = 11'd160;
    localparam logic [10:0] HALF_KEY_H  = 11'd80;

    localparam logic [5:0] MAIN_KEYS     = 6'd49;
    localparam logic [7:0] KEYS_PER_OCT  = 8'd7;
    localparam logic [7:0] CODES_PER_OCT = 8'd12;

    localparam int PIPE_DEPTH = 2;  // renderer latency in clocks

    typedef struct packed {
        logic [3:0] red;
        logic [3:0] green;
        logic [3:0] blue;
    } rgb_t;

    localparam rgb_t C_BLACK  = 12'h000;
    localparam rgb_t C_WHITE  = 12'hfff;
    localparam rgb_t C_YELLOW = 12'hff0;
    localparam rgb_t C_BLUE   = 12'h00f;
    localparam rgb_t C_GREEN  = 12'h0f0;

    typedef enum logic [1:0] {
        NOTE_NONE,
        NOTE_MAIN,
        NOTE_HALF
    } note_kind_t;

    // region code passed from renderer stage 1 to stage 2
    typedef enum logic [2:0] {
        REG_BG,
        REG_PROGRESS,
        REG_TITLE,
        REG_MAIN_KEY,
        REG_KEY_GAP,
        REG_HALF_KEY
    } region_t;

    typedef struct packed {
        logic [10:0] x;
        logic [10:0] y;
        logic        active;
        logic        hsync;
        logic        vsync;
    } scan_pos_t;

    typedef struct packed {
        note_kind_t kind;
        logic [5:0] idx;
    } key_sel_t;

endpackage

// File: hdl/vga_timing.sv
`timescale 1ns/1ps

module vga_timing (
    input  logic                   clk_vga,
    input  logic                   iReset_n,
    output display_pkg::scan_pos_t pos
);
    import display_pkg::*;

    // counter values for the coming pixel
    logic [10:0] h_next;
    logic [10:0] v_next;
    logic        h_sync_next;
    logic        v_sync_next;

    always_comb begin
        h_next = pos.x + 11'd1;
        v_next = pos.y;
        if (pos.x == H_TOTAL - 11'd1) begin
            h_next = '0;
            // step one line at the end of each line
            if (pos.y == V_TOTAL - 11'd1) begin
                v_next = '0;
            end else begin
                v_next = pos.y + 11'd1;
            end
        end
    end

    assign h_sync_next = (h_next >= H_DISP + H_FRONT) &&
                         (h_next < H_DISP + H_FRONT + H_SYNC);
    assign v_sync_next = (v_next >= V_DISP + V_FRONT) &&
                         (v_next < V_DISP + V_FRONT + V_SYNC);

    // pos.x and pos.y are the counters themselves, flags follow in step
    always_ff @(posedge clk_vga or negedge iReset_n) begin
        if (!iReset_n) begin
            pos.x      <= '0;
            pos.y      <= '0;
            pos.active <= 1'b1;  // pixel 0,0 is visible
            pos.hsync  <= 1'b0;
            pos.vsync  <= 1'b0;
        end else begin
            pos.x      <= h_next;
            pos.y      <= v_next;
            pos.active <= (h_next < H_DISP) && (v_next < V_DISP);
            pos.hsync  <= h_sync_next;  // active high
            pos.vsync  <= v_sync_next;
        end
    end

endmodule

// File: hdl/note_decoder.sv
`timescale 1ns/1ps

module note_decoder (
    input  logic                  clk_vga,
    input  logic                  iReset_n,
    input  logic [7:0]            freq_type,
    output display_pkg::key_sel_t key_sel
);
    import display_pkg::*;

    logic [7:0] rel_code;  // code past the first seven keys
    logic [7:0] rem_code;
    logic [7:0] oct_base;
    logic [7:0] key_num;
    note_kind_t kind_c;

    always_comb begin
        rel_code = freq_type - 8'd7;
        rem_code = rel_code % CODES_PER_OCT;
        oct_base = (rel_code / CODES_PER_OCT) * KEYS_PER_OCT;
        kind_c   = NOTE_MAIN;
        key_num  = 8'd0;
        if (freq_type == 8'd0) begin
            kind_c = NOTE_NONE;
        end else if (freq_type <= 8'd7) begin
            key_num = freq_type - 8'd1;  // lowest partial octave, white keys only
        end else begin
            case (rem_code)
                8'd0:    key_num = oct_base + 8'd6;
                8'd1:    key_num = oct_base + 8'd7;
                8'd3:    key_num = oct_base + 8'd8;
                8'd5:    key_num = oct_base + 8'd9;
                8'd6:    key_num = oct_base + 8'd10;
                8'd8:    key_num = oct_base + 8'd11;
                8'd10:   key_num = oct_base + 8'd12;
                8'd2:    key_num = oct_base + 8'd8;
                8'd4:    key_num = oct_base + 8'd9;
                8'd7:    key_num = oct_base + 8'd11;
                8'd9:    key_num = oct_base + 8'd12;
                8'd11:   key_num = oct_base + 8'd13;
                default: kind_c = NOTE_NONE;
            endcase
            // black keys of the octave
            if (rem_code == 8'd2 || rem_code == 8'd4 || rem_code == 8'd7 ||
                rem_code == 8'd9 || rem_code == 8'd11) begin
                kind_c = NOTE_HALF;
            end
        end
        // off the right end of the keyboard
        if (key_num >= {2'b00, MAIN_KEYS}) begin
            kind_c = NOTE_NONE;
        end
    end

    always_ff @(posedge clk_vga or negedge iReset_n) begin
        if (!iReset_n) begin
            key_sel.kind <= NOTE_NONE;
            key_sel.idx  <= '0;
        end else begin
            key_sel.kind <= kind_c;
            key_sel.idx  <= (kind_c == NOTE_NONE) ? 6'd0 : key_num[5:0];
        end
    end

endmodule

// File: hdl/title_rom.sv
`timescale 1ns/1ps

module title_rom (
    input  logic        clk_vga,
    input  logic [4:0]  addr,
    output logic [63:0] bits
);

    // rows 0..15 first song, 16..31 second song
    logic [63:0] glyph_mem [0:31];

    initial begin
        $readmemh("hdl/title_glyphs.hex", glyph_mem);
    end

    // one clock read latency, like a block RAM
    always_ff @(posedge clk_vga) begin
        bits <= glyph_mem[addr];
    end

endmodule

// File: hdl/scene_renderer.sv
`timescale 1ns/1ps

module scene_renderer (
    input  logic                   clk_vga,
    input  logic                   iReset_n,
    input  display_pkg::scan_pos_t pos,
    input  display_pkg::key_sel_t  key_sel,
    input  logic [6:0]             progress,
    input  logic [3:0]             song_sel,
    output logic [4:0]             rom_addr,
    input  logic [63:0]            rom_bits,
    output display_pkg::rgb_t      colour
);
    import display_pkg::*;

    // running pitch counters, they describe the pixel in pos
    logic [4:0] main_pos;
    logic [5:0] main_idx;
    logic [4:0] half_pos;
    logic [5:0] half_idx;

    logic [10:0] key_y;
    logic [10:0] prog_x;
    logic [10:0] title_x;
    logic [10:0] title_y;
    logic [10:0] fill_len;
    logic [7:0]  half_oct;
    logic        song_ok;
    logic        in_keys;
    logic        in_title;
    logic        in_prog;
    logic        half_hit;
    region_t     region_c;

    region_t     region_q;
    logic [5:0]  main_idx_q;
    logic [5:0]  half_idx_q;
    logic        prog_fill_q;
    logic [5:0]  title_col_q;

    always_ff @(posedge clk_vga or negedge iReset_n) begin
        if (!iReset_n) begin
            main_pos <= '0;
            main_idx <= '0;
            half_pos <= '0;
            half_idx <= '0;
        end else begin
            if (pos.x == KEY_LEFT - 11'd1) begin  // next pixel starts key 0
                main_pos <= '0;
                main_idx <= '0;
            end else if (main_pos == KEY_PITCH - 5'd1) begin
                main_pos <= '0;
                main_idx <= main_idx + 6'd1;
            end else begin
                main_pos <= main_pos + 5'd1;
            end

            if (pos.x == KEY_LEFT - 11'd1) begin
                half_pos <= '0;
                half_idx <= '0;
            end else if (pos.x == KEY_LEFT + HALF_OFFSET - 11'd1) begin
                half_pos <= '0;
                half_idx <= 6'd1;  // sharp n sits left of main key n
            end else if (half_pos == KEY_PITCH - 5'd1) begin
                half_pos <= '0;
                half_idx <= half_idx + 6'd1;
            end else begin
                half_pos <= half_pos + 5'd1;
            end
        end
    end

    always_comb begin
        key_y    = pos.y - KEY_TOP;
        prog_x   = pos.x - PROG_LEFT;
        title_x  = pos.x - TITLE_LEFT;
        title_y  = pos.y - TITLE_TOP;
        fill_len = PROG_STEP * {4'd0, progress};
        half_oct = {2'b00, half_idx} % KEYS_PER_OCT;
        song_ok  = (song_sel == 4'd1) || (song_sel == 4'd2);
        in_keys  = pos.active && (pos.x >= KEY_LEFT) && (pos.y >= KEY_TOP) &&
                   (key_y < MAIN_KEY_H);
        in_title = pos.active && (pos.x >= TITLE_LEFT) && (title_x < TITLE_W) &&
                   (pos.y >= TITLE_TOP) && (title_y < TITLE_H);
        in_prog  = pos.active && (pos.x >= PROG_LEFT) && (prog_x < PROG_W) &&
                   (pos.y >= PROG_TOP) && (pos.y - PROG_TOP < PROG_H);
        // no sharp between E-F and B-C
        half_hit = (key_y < HALF_KEY_H) && (half_idx < MAIN_KEYS) &&
                   (half_oct != 8'd0) && (half_oct != 8'd3) && (half_pos >= KEY_GAP);

        if (in_keys) begin
            if (half_hit) begin
                region_c = REG_HALF_KEY;
            end else if (main_idx >= MAIN_KEYS) begin
                region_c = REG_BG;
            end else if (main_pos < KEY_GAP) begin
                region_c = REG_KEY_GAP;
            end else begin
                region_c = REG_MAIN_KEY;
            end
        end else if (in_title && song_ok) begin
            region_c = REG_TITLE;
        end else if (in_prog) begin
            region_c = REG_PROGRESS;
        end else begin
            region_c = REG_BG;
        end
    end

    // song 2 in the upper half of the ROM
    assign rom_addr = {song_sel[1], title_y[3:0]};

    always_ff @(posedge clk_vga or negedge iReset_n) begin
        if (!iReset_n) begin
            region_q <= REG_BG;
        end else begin
            region_q <= region_c;
        end
    end

    always_ff @(posedge clk_vga) begin
        main_idx_q  <= main_idx;
        half_idx_q  <= half_idx;
        prog_fill_q <= prog_x < fill_len;
        title_col_q <= title_x[5:0];
    end

    always_ff @(posedge clk_vga or negedge iReset_n) begin
        if (!iReset_n) begin
            colour <= C_BLACK;
        end else begin
            case (region_q)
                REG_MAIN_KEY: colour <= (key_sel.kind == NOTE_MAIN &&
                                         key_sel.idx == main_idx_q) ? C_GREEN : C_WHITE;
                REG_HALF_KEY: colour <= (key_sel.kind == NOTE_HALF &&
                                         key_sel.idx == half_idx_q) ? C_GREEN : C_YELLOW;
                REG_KEY_GAP:  colour <= C_BLUE;
                REG_PROGRESS: colour <= prog_fill_q ? C_YELLOW : C_GREEN;
                // leftmost pixel is the msb of the glyph row
                REG_TITLE:    colour <= rom_bits[6'd63 - title_col_q] ? C_WHITE : C_BLACK;
                default:      colour <= C_BLACK;
            endcase
        end
    end

endmodule

// File: hdl/pixel_output.sv
`timescale 1ns/1ps

module pixel_output (
    input  logic                   clk_vga,
    input  logic                   iReset_n,
    input  display_pkg::scan_pos_t pos,
    input  display_pkg::rgb_t      colour,
    output logic                   hsync,
    output logic                   vsync,
    output logic [3:0]             red,
    output logic [3:0]             green,
    output logic [3:0]             blue
);
    import display_pkg::*;

    // sync and active follow the renderer pipeline
    logic [PIPE_DEPTH-1:0] hs_pipe;
    logic [PIPE_DEPTH-1:0] vs_pipe;
    logic [PIPE_DEPTH-1:0] act_pipe;

    always_ff @(posedge clk_vga or negedge iReset_n) begin
        if (!iReset_n) begin
            hs_pipe  <= '0;
            vs_pipe  <= '0;
            act_pipe <= '0;
            hsync    <= 1'b0;
            vsync    <= 1'b0;
            red      <= '0;
            green    <= '0;
            blue     <= '0;
        end else begin
            hs_pipe  <= {hs_pipe[PIPE_DEPTH-2:0], pos.hsync};
            vs_pipe  <= {vs_pipe[PIPE_DEPTH-2:0], pos.vsync};
            act_pipe <= {act_pipe[PIPE_DEPTH-2:0], pos.active};
            hsync    <= hs_pipe[PIPE_DEPTH-1];
            vsync    <= vs_pipe[PIPE_DEPTH-1];
            red      <= act_pipe[PIPE_DEPTH-1] ? colour.red : 4'd0;  // black in blanking
            green    <= act_pipe[PIPE_DEPTH-1] ? colour.green : 4'd0;
            blue     <= act_pipe[PIPE_DEPTH-1] ? colour.blue : 4'd0;
        end
    end

endmodule

// File: hdl/piano_display.sv
`timescale 1ns/1ps

module piano_display (
    input  logic       clk_vga,
    input  logic       iReset_n,
    input  logic [7:0] freq_type,
    input  logic [6:0] progress,
    input  logic [3:0] song_sel,
    output logic       hsync,
    output logic       vsync,
    output logic [3:0] red,
    output logic [3:0] green,
    output logic [3:0] blue
);
    import display_pkg::*;

    scan_pos_t   pos;
    key_sel_t    key_sel;
    logic [4:0]  rom_addr;
    logic [63:0] rom_bits;
    rgb_t        colour;

    vga_timing u_timing (
        .clk_vga  (clk_vga),
        .iReset_n (iReset_n),
        .pos      (pos)
    );

    note_decoder u_decoder (
        .clk_vga   (clk_vga),
        .iReset_n  (iReset_n),
        .freq_type (freq_type),
        .key_sel   (key_sel)
    );

    title_rom u_title_rom (
        .clk_vga (clk_vga),
        .addr    (rom_addr),
        .bits    (rom_bits)
    );

    scene_renderer u_renderer (
        .clk_vga  (clk_vga),
        .iReset_n (iReset_n),
        .pos      (pos),
        .key_sel  (key_sel),
        .progress (progress),
        .song_sel (song_sel),
        .rom_addr (rom_addr),
        .rom_bits (rom_bits),
        .colour   (colour)
    );

    pixel_output u_output (
        .clk_vga  (clk_vga),
        .iReset_n (iReset_n),
        .pos      (pos),
        .colour   (colour),
        .hsync    (hsync),
        .vsync    (vsync),
        .red      (red),
        .green    (green),
        .blue     (blue)
    );

endmodule

// File: tb/piano_display_tb.sv
`timescale 1ns/1ps

module piano_display_tb;
    import display_pkg::*;

    logic       clk_vga;
    logic       iReset_n;
    logic [7:0] freq_type;
    logic [6:0] progress;
    logic [3:0] song_sel;
    logic       hsync;
    logic       vsync;
    logic [3:0] red;
    logic [3:0] green;
    logic [3:0] blue;

    logic [63:0] glyph_ref [0:31];  // model copy of the title glyphs
    logic [31:0] rnd_state;

    // pin position rebuilt from the sync edges
    int   col;
    int   row;
    logic hs_prev;
    logic vs_prev;
    logic locked;
    logic chk_en = 1'b0;
    rgb_t exp_col;
    int   hs_len;
    int   vs_len;
    int   line_len;
    int   frame_len;
    int   green_cnt;
    int   key_lines;

    piano_display u_dut (
        .clk_vga   (clk_vga),
        .iReset_n  (iReset_n),
        .freq_type (freq_type),
        .progress  (progress),
        .song_sel  (song_sel),
        .hsync     (hsync),
        .vsync     (vsync),
        .red       (red),
        .green     (green),
        .blue      (blue)
    );

    initial begin
        clk_vga = 1'b0;
        forever #2 clk_vga = ~clk_vga;
    end

    task automatic fail_now(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input int got, input int expv);
        fail_now($sformatf("MISMATCH time=%0t signal=%s got=%0h expected=%0h",
                           $time, name, got, expv));
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // frequency code to key by the octave table
    function automatic void decode_note(input logic [7:0] code, output note_kind_t kind,
                                        output int idx);
        int rel;
        int b;
        kind = NOTE_NONE;
        idx  = 0;
        if (code >= 8'd1 && code <= 8'd7) begin
            kind = NOTE_MAIN;
            idx  = int'(code) - 1;
        end else if (code > 8'd7) begin
            rel  = int'(code) - 7;
            b    = (rel / 12) * 7;
            kind = NOTE_MAIN;
            case (rel % 12)
                0:  idx = b + 6;
                1:  idx = b + 7;
                3:  idx = b + 8;
                5:  idx = b + 9;
                6:  idx = b + 10;
                8:  idx = b + 11;
                10: idx = b + 12;
                default: kind = NOTE_HALF;
            endcase
            if (kind == NOTE_HALF) begin
                case (rel % 12)
                    2:       idx = b + 8;
                    4:       idx = b + 9;
                    7:       idx = b + 11;
                    9:       idx = b + 12;
                    default: idx = b + 13;
                endcase
            end else if (idx >= int'(MAIN_KEYS)) begin
                kind = NOTE_NONE;  // past the last key
            end
        end
    endfunction

    function automatic rgb_t model_colour(input int cx, input int cy,
                                          input note_kind_t kind, input int idx);
        int          kx;
        int          ky;
        int          mi;
        int          mp;
        int          hi;
        int          hp;
        logic [63:0] glyph_row;
        if (cx >= int'(H_DISP) || cy >= int'(V_DISP)) begin
            return C_BLACK;
        end
        ky = cy - int'(KEY_TOP);
        if (cx >= int'(KEY_LEFT) && ky >= 0 && ky < int'(MAIN_KEY_H)) begin
            kx = cx - int'(KEY_LEFT);
            mi = kx / int'(KEY_PITCH);
            mp = kx % int'(KEY_PITCH);
            hi = 0;  // left of the first sharp
            hp = kx;
            if (kx >= int'(HALF_OFFSET)) begin
                hi = (kx - int'(HALF_OFFSET)) / int'(KEY_PITCH) + 1;
                hp = (kx - int'(HALF_OFFSET)) % int'(KEY_PITCH);
            end
            if (ky < int'(HALF_KEY_H) && hi < int'(MAIN_KEYS) && hi % 7 != 0 &&
                hi % 7 != 3 && hp >= int'(KEY_GAP)) begin
                return (kind == NOTE_HALF && idx == hi) ? C_GREEN : C_YELLOW;
            end
            if (mi >= int'(MAIN_KEYS)) begin
                return C_BLACK;
            end
            if (mp < int'(KEY_GAP)) begin
                return C_BLUE;
            end
            return (kind == NOTE_MAIN && idx == mi) ? C_GREEN : C_WHITE;
        end
        if (cx >= int'(TITLE_LEFT) && cx < int'(TITLE_LEFT + TITLE_W) &&
            cy >= int'(TITLE_TOP) && cy < int'(TITLE_TOP + TITLE_H) &&
            (song_sel == 4'd1 || song_sel == 4'd2)) begin
            glyph_row = glyph_ref[(song_sel == 4'd2 ? 16 : 0) + cy - int'(TITLE_TOP)];
            return glyph_row[63 - (cx - int'(TITLE_LEFT))] ? C_WHITE : C_BLACK;
        end
        if (cx >= int'(PROG_LEFT) && cx < int'(PROG_LEFT + PROG_W) &&
            cy >= int'(PROG_TOP) && cy < int'(PROG_TOP + PROG_H)) begin
            return (cx - int'(PROG_LEFT) < 9 * int'(progress)) ? C_YELLOW : C_GREEN;
        end
        return C_BLACK;
    endfunction

    task automatic wait_line_start(output logic vs_level);
        logic last;
        logic hit;
        int   waited;
        @(negedge clk_vga);
        last   = hsync;
        waited = 0;
        do begin
            @(negedge clk_vga);
            waited++;
            if (waited > int'(H_TOTAL) + 8) begin
                fail_now("timeout while waiting for a rising edge of hsync");
            end
            hit  = hsync && !last;
            last = hsync;
        end while (!hit);
        vs_level = vsync;
    endtask

    // pin tracking and model on the falling edge
    always @(negedge clk_vga) begin
        note_kind_t sel_kind;
        int         sel_idx;
        int         exp_px;
        logic       hs_rise;
        logic       vs_rise;
        if (!iReset_n) begin
            col        = 0;
            row        = 0;
            hs_prev    = 1'b0;
            vs_prev    = 1'b0;
            locked     = 1'b0;
            chk_en     = 1'b0;
            hs_len     = 0;
            vs_len     = 0;
            line_len   = 0;
            frame_len  = 0;
            green_cnt  = 0;
            key_lines  = 0;
        end else begin
            hs_rise = hsync && !hs_prev;
            vs_rise = vsync && !vs_prev;
            if (hsync) begin
                hs_len++;
            end else if (hs_prev) begin
                assert (hs_len == int'(H_SYNC))
                    else report_mismatch("hsync_width", hs_len, int'(H_SYNC));
                hs_len = 0;
            end
            if (vsync) begin
                vs_len++;
            end else if (vs_prev) begin
                assert (vs_len == int'(V_SYNC) * int'(H_TOTAL))
                    else report_mismatch("vsync_width", vs_len, int'(V_SYNC) * int'(H_TOTAL));
                vs_len = 0;
            end
            if (hs_rise) begin
                if (locked) begin
                    assert (line_len == int'(H_TOTAL))
                        else report_mismatch("line_period", line_len, int'(H_TOTAL));
                end
                line_len = 0;
            end
            line_len++;
            if (vs_rise) begin
                if (locked) begin
                    assert (frame_len == int'(V_TOTAL) * int'(H_TOTAL))
                        else report_mismatch("frame_period", frame_len,
                                             int'(V_TOTAL) * int'(H_TOTAL));
                end
                frame_len = 0;
            end
            frame_len++;

            if (hs_rise) begin
                col = int'(H_DISP + H_FRONT);
            end else if (col == int'(H_TOTAL) - 1) begin
                col = 0;
                row = (row == int'(V_TOTAL) - 1) ? 0 : row + 1;
            end else begin
                col++;
            end
            if (vs_rise) begin
                row    = int'(V_DISP + V_FRONT);
                locked = 1'b1;
            end
            hs_prev = hsync;
            vs_prev = vsync;

            decode_note(freq_type, sel_kind, sel_idx);
            exp_col = model_colour(col, row, sel_kind, sel_idx);
            chk_en  = locked;
            if (locked) begin
                if (col == 0) begin
                    green_cnt = 0;
                end
                if (col < int'(H_DISP) && {red, green, blue} == C_GREEN) begin
                    green_cnt++;
                end
                // exactly one green key face on this line
                if (col == int'(H_DISP) - 1 && row == int'(KEY_TOP) + 100) begin
                    key_lines++;
                    exp_px = (sel_kind == NOTE_MAIN) ? int'(KEY_PITCH - KEY_GAP) : 0;
                    assert (green_cnt == exp_px)
                        else report_mismatch("green_main_px", green_cnt, exp_px);
                end
                if (col == int'(H_DISP) - 1 && row == int'(KEY_TOP) + 10 &&
                    sel_kind != NOTE_MAIN) begin
                    exp_px = (sel_kind == NOTE_HALF && sel_idx < int'(MAIN_KEYS)) ?
                             int'(KEY_PITCH - KEY_GAP) : 0;
                    assert (green_cnt == exp_px)
                        else report_mismatch("green_half_px", green_cnt, exp_px);
                end
            end
        end
    end

    assert property (@(posedge clk_vga) disable iff (!chk_en) red == exp_col.red)
        else report_mismatch("red", $sampled(red), $sampled(exp_col.red));
    assert property (@(posedge clk_vga) disable iff (!chk_en) green == exp_col.green)
        else report_mismatch("green", $sampled(green), $sampled(exp_col.green));
    assert property (@(posedge clk_vga) disable iff (!chk_en) blue == exp_col.blue)
        else report_mismatch("blue", $sampled(blue), $sampled(exp_col.blue));

    initial begin
        int   frame;
        int   lines;
        logic vs_level;
        logic vs_last;
        iReset_n  = 1'b0;
        freq_type = 8'd0;
        progress  = 7'd50;
        song_sel  = 4'd1;
        rnd_state = 32'h8c44_f6ac;
        frame     = 0;
        lines     = 0;
        vs_last   = 1'b0;
        $readmemh("hdl/title_glyphs.hex", glyph_ref);

        repeat (15) @(posedge clk_vga);
        @(negedge clk_vga);
        assert (hsync === 1'b0 && vsync === 1'b0 && red === 4'd0 && green === 4'd0 &&
                blue === 4'd0)
            else fail_now("sync and colour pins are not cleared during reset");
        @(posedge clk_vga);
        iReset_n <= 1'b1;

        while (frame < 4) begin
            wait_line_start(vs_level);
            @(posedge clk_vga);
            // new note each line during horizontal blanking
            rnd_state = xorshift32(rnd_state);
            freq_type <= 8'(rnd_state % 32'd100);
            if (vs_level && !vs_last) begin
                frame++;
                rnd_state = xorshift32(rnd_state);
                case (frame)
                    1: begin
                        progress <= 7'd0;
                        song_sel <= 4'd1;
                    end
                    2: begin
                        progress <= 7'd100;
                        song_sel <= 4'd2;
                    end
                    default: begin
                        progress <= 7'(rnd_state % 32'd101);
                        song_sel <= (rnd_state[7:4] inside {4'd1, 4'd2}) ?
                                    4'd8 : rnd_state[7:4];  // no title
                    end
                endcase
            end
            vs_last = vs_level;
            lines++;
            if (lines > 5 * int'(V_TOTAL)) begin
                fail_now("vsync did not start a new frame in time");
            end
        end

        if (key_lines == 3) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            $display("*** FAILED ***");
            $fatal(1, "too few key lines were checked");
        end
    end

endmodule

// File: vlog.f
hdl/display_pkg.sv
hdl/vga_timing.sv
hdl/note_decoder.sv
hdl/title_rom.sv
hdl/scene_renderer.sv
hdl/pixel_output.sv
hdl/piano_display.sv
tb/piano_display_tb.sv

// File: hdl/title_glyphs.hex
// one 64-bit glyph row per line, msb is the leftmost pixel
// lines 0-15 hold song 1, lines 16-31 hold song 2
0000000000000000
3C663C7E18663C00
6066667E3C666600
6066661866666000
3C7E661866663C00
0666661866660600
0666661866660600
3C663C187E3C3C00
0000000000000000
0000000000000000
7E7E7E7E7E7E7E00
0000000000000000
183C7E7E3C180000
0000000000000000
0000000000000000
0000000000000000
0000000000000000
7C3C663C7E7C3C00
66667E6660666600
66667E6660666000
7C66666678663C00
6C66666660660600
66666666607C0600
663C663C7E603C00
0000000000000000
0000000000000000
7E7E7E7E7E7E7E00
0000000000000000
00183C7E7E3C1800
0000000000000000
0000000000000000
0000000000000000
